// File: compile.f
+incdir+include
design/imm_pkg.sv
design/imm_fetch_ctrl.sv
design/imm_tlb_ram.sv
design/imm_translate.sv
design/imm_pc_track.sv
design/imm_top.sv
verif/tb_clk_gen.sv
verif/tb_imm_checker.sv
verif/tb_imm_top.sv

// File: design/imm_fetch_ctrl.sv
// Command stage FSM and flush handling between fetch unit and icache; instantiated by imm_top
`timescale 1ns/10ps
`default_nettype none

module imm_fetch_ctrl
   import imm_pkg::*;
(
   input  wire  clk,
   input  wire  rst_n,
   input  wire  cmd_valid,
   output logic cmd_ready,
   input  wire  icache_cmd_ready,
   output logic icache_cmd_valid,
   input  wire  flush_req,
   output logic flush_ack,
   output logic tlb_read,
   output logic icache_fire
);

   ctrl_state_t state_r;
   ctrl_state_t state_nxt;
   logic        up_r;
   logic        flush_hold_r;
   logic        flush_strobe;
   logic        held;
   logic        leave;

   //////////////////////////////////////////////////
   // Flush strobe
   //////////////////////////////////////////////////

   // Icache took a command while flushing
   // so the same flush must not cancel the next one
   assign flush_strobe = flush_req & ~flush_hold_r;

   //////////////////////////////////////////////////
   // Command stage
   //////////////////////////////////////////////////

   assign held  = (state_r == CMD_HELD);
   // Held command goes to icache or is dropped
   assign leave = held & (icache_cmd_ready | flush_strobe);

   // Bypassing stage, accepts while the held one leaves
   assign cmd_ready = up_r & (~held | icache_cmd_ready | flush_strobe);
   assign tlb_read  = cmd_valid & cmd_ready;

   // Strobe cancels the request to icache
   assign icache_cmd_valid = held & ~flush_strobe;
   assign icache_fire      = icache_cmd_valid & icache_cmd_ready;

   // Flush done once the new command is taken
   assign flush_ack = tlb_read & ~flush_strobe;

   always_comb begin
      state_nxt = state_r;
      if (tlb_read) begin
         state_nxt = CMD_HELD;
      end else if (leave) begin
         state_nxt = CMD_EMPTY;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_r      <= CMD_EMPTY;
         up_r         <= 1'b0;
         flush_hold_r <= 1'b0;
      end else begin
         state_r      <= state_nxt;
         // Ready opens one cycle out of reset
         up_r         <= 1'b1;
         flush_hold_r <= held & icache_cmd_ready & flush_req;
      end
   end

endmodule

`default_nettype wire

// File: design/imm_pc_track.sv
// Tracks the address of the instruction at the output and of the next one; used by imm_top
`timescale 1ns/10ps
`default_nettype none

`include "imm_params.svh"

module imm_pc_track
   import imm_pkg::*;
(
   input  wire   clk,
   input  wire   rst_n,
   input  wire   tlb_read,
   input  wire   ibus_fire,
   input  wire   flush_req,
   input  addr_t cmd_addr,
   output addr_t out_id,
   output addr_t out_id_nxt
);

   addr_t id_load;

   // Flush takes the presented address directly
   assign id_load = flush_req ? cmd_addr : out_id_nxt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_id_nxt <= `IMM_RESET_VECTOR - 32'd4;
         out_id     <= `IMM_RESET_VECTOR;
      end else begin
         // Next address follows the TLB read
         if (tlb_read) begin
            out_id_nxt <= cmd_addr;
         end
         // Current address follows the data handshake
         if (ibus_fire | flush_req) begin
            out_id <= id_load;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/imm_pkg.sv
// Shared types of the instruction MMU; modules pull them in by a wildcard import
`default_nettype none

`include "imm_params.svh"

package imm_pkg;

   //////////////////////////////////////////////////
   // Plain vectors
   //////////////////////////////////////////////////

   typedef logic [`IMM_AW-1:0] addr_t;
   typedef logic [`IMM_IW-1:0] insn_t;
   typedef logic [`IMM_DW-1:0] word_t;

   // Page number and offset split of an address
   typedef logic [`IMM_AW-`IMM_PAGE_SHIFT-1:0] vpn_t;
   typedef logic [`IMM_AW-`IMM_PAGE_SHIFT-1:0] ppn_t;
   typedef logic [`IMM_PAGE_SHIFT-1:0] page_off_t;

   typedef logic [`IMM_TLB_SETS_LOG2-1:0] tlb_idx_t;

   //////////////////////////////////////////////////
   // TLB words
   //////////////////////////////////////////////////

   // Low word, tag side
   typedef struct packed {
      vpn_t        vpn;
      logic [11:0] rsvd;
      logic        v;
   } tlb_lo_t;

   // High word, translation and permissions
   typedef struct packed {
      ppn_t       ppn;
      logic [3:0] rsvd1;
      logic       s;
      logic [2:0] rsvd0;
      logic       rx;
      logic       ux;
      logic [1:0] rsvdp;
      logic       p;
   } tlb_hi_t;

   // Software access port of one TLB half
   typedef struct packed {
      tlb_idx_t idx;
      logic     we;
      word_t    data;
   } tlb_wr_t;

   // Accepted fetch with its mode bits
   typedef struct packed {
      addr_t addr;
      logic  imme;
      logic  rm;
   } fetch_req_t;

   // One-deep command stage
   typedef enum logic {
      CMD_EMPTY,
      CMD_HELD
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/imm_tlb_ram.sv
// One half of the direct-mapped TLB with lookup and software ports; two copies live in imm_top
`timescale 1ns/10ps
`default_nettype none

`include "imm_params.svh"

module imm_tlb_ram
   import imm_pkg::*;
(
   input  wire      clk,
   input  wire      rst_n,
   input  tlb_idx_t lookup_idx,
   input  wire      lookup_en,
   output word_t    lookup_data,
   input  tlb_wr_t  sw_port,
   output word_t    sw_data
);

   word_t mem [0:(1<<`IMM_TLB_SETS_LOG2)-1];

   logic  bypass;

   // Software write to the set under lookup
   assign bypass = sw_port.we & (sw_port.idx == lookup_idx);

   always_ff @(posedge clk) begin
      if (sw_port.we) begin
         mem[sw_port.idx] <= sw_port.data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lookup_data <= '0;
         sw_data     <= '0;
      end else begin
         // Lookup port, only on a TLB read
         if (lookup_en) begin
            lookup_data <= bypass ? sw_port.data : mem[lookup_idx];
         end
         // Software port is write-first
         sw_data <= sw_port.we ? sw_port.data : mem[sw_port.idx];
      end
   end

endmodule

`default_nettype wire

// File: design/imm_top.sv
// Instruction MMU top between fetch unit and icache; the DUT of the testbench
`timescale 1ns/10ps
`default_nettype none

`include "imm_params.svh"

module imm_top
   import imm_pkg::*;
(
   input  wire     clk,
   input  wire     rst_n,
   // ibus command
   input  wire     cmd_valid,
   input  addr_t   cmd_addr,
   output logic    cmd_ready,
   // ibus data
   output logic    ibus_valid,
   output insn_t   ibus_dout,
   input  wire     ibus_ready,
   // icache command
   output logic    icache_cmd_valid,
   output addr_t   icache_cmd_addr,
   input  wire     icache_cmd_ready,
   // icache data
   input  wire     icache_valid,
   input  insn_t   icache_dout,
   output logic    icache_ready,
   // Flush
   input  wire     flush_req,
   output logic    flush_ack,
   // Mode bits
   input  wire     psr_imme,
   input  wire     psr_rm,
   // TLB software ports
   input  tlb_wr_t tlbl_wr,
   input  tlb_wr_t tlbh_wr,
   output word_t   tlbl_rd,
   output word_t   tlbh_rd,
   // Exceptions and tracking
   output logic    tlb_miss,
   output logic    page_fault,
   output addr_t   out_id,
   output addr_t   out_id_nxt
);

   logic     tlb_read;
   logic     icache_fire;
   logic     ibus_fire;
   vpn_t     cmd_vpn;
   tlb_idx_t set_idx;
   tlb_lo_t  tlb_lo;
   tlb_hi_t  tlb_hi;

   //////////////////////////////////////////////////
   // Data path, straight through
   //////////////////////////////////////////////////

   assign ibus_valid   = icache_valid;
   assign ibus_dout    = icache_dout;
   assign icache_ready = ibus_ready;
   assign ibus_fire    = ibus_valid & ibus_ready;

   // Set index from low vpn bits
   assign cmd_vpn = cmd_addr[`IMM_AW-1:`IMM_PAGE_SHIFT];
   assign set_idx = cmd_vpn[`IMM_TLB_SETS_LOG2-1:0];

   imm_fetch_ctrl u_ctrl (
      .clk              (clk),
      .rst_n            (rst_n),
      .cmd_valid        (cmd_valid),
      .cmd_ready        (cmd_ready),
      .icache_cmd_ready (icache_cmd_ready),
      .icache_cmd_valid (icache_cmd_valid),
      .flush_req        (flush_req),
      .flush_ack        (flush_ack),
      .tlb_read         (tlb_read),
      .icache_fire      (icache_fire)
   );

   //////////////////////////////////////////////////
   // TLB halves
   //////////////////////////////////////////////////

   imm_tlb_ram tlb_lo_ram (
      .clk         (clk),
      .rst_n       (rst_n),
      .lookup_idx  (set_idx),
      .lookup_en   (tlb_read),
      .lookup_data (tlb_lo),
      .sw_port     (tlbl_wr),
      .sw_data     (tlbl_rd)
   );

   imm_tlb_ram tlb_hi_ram (
      .clk         (clk),
      .rst_n       (rst_n),
      .lookup_idx  (set_idx),
      .lookup_en   (tlb_read),
      .lookup_data (tlb_hi),
      .sw_port     (tlbh_wr),
      .sw_data     (tlbh_rd)
   );

   imm_translate u_xlate (
      .clk             (clk),
      .rst_n           (rst_n),
      .tlb_read        (tlb_read),
      .icache_fire     (icache_fire),
      .cmd_addr        (cmd_addr),
      .psr_imme        (psr_imme),
      .psr_rm          (psr_rm),
      .tlb_lo          (tlb_lo),
      .tlb_hi          (tlb_hi),
      .icache_cmd_addr (icache_cmd_addr),
      .tlb_miss        (tlb_miss),
      .page_fault      (page_fault)
   );

   imm_pc_track u_pc (
      .clk        (clk),
      .rst_n      (rst_n),
      .tlb_read   (tlb_read),
      .ibus_fire  (ibus_fire),
      .flush_req  (flush_req),
      .cmd_addr   (cmd_addr),
      .out_id     (out_id),
      .out_id_nxt (out_id_nxt)
   );

endmodule

`default_nettype wire

// File: design/imm_translate.sv
// Address translation and exception flags for the fetch at the icache port; used by imm_top
`timescale 1ns/10ps
`default_nettype none

module imm_translate
   import imm_pkg::*;
(
   input  wire     clk,
   input  wire     rst_n,
   input  wire     tlb_read,
   input  wire     icache_fire,
   input  addr_t   cmd_addr,
   input  wire     psr_imme,
   input  wire     psr_rm,
   input  tlb_lo_t tlb_lo,
   input  tlb_hi_t tlb_hi,
   output addr_t   icache_cmd_addr,
   output logic    tlb_miss,
   output logic    page_fault
);

   fetch_req_t req_r;
   vpn_t       req_vpn;
   page_off_t  req_off;
   ppn_t       ppn;
   logic       perm_denied;
   logic       miss_nxt;
   logic       fault_nxt;

   // Request sampled together with the TLB read
   always_ff @(posedge clk) begin
      if (tlb_read) begin
         req_r <= '{addr: cmd_addr, imme: psr_imme, rm: psr_rm};
      end
   end

   assign {req_vpn, req_off} = req_r.addr;
   assign ppn = tlb_hi.ppn;

   // Translated or pass-through address
   assign icache_cmd_addr = req_r.imme ? {ppn, req_off} : req_r.addr;

   //////////////////////////////////////////////////
   // Exceptions
   //////////////////////////////////////////////////

   // Supervisor needs rx, user needs ux
   assign perm_denied = req_r.rm ? ~tlb_hi.rx : ~tlb_hi.ux;

   assign miss_nxt  = req_r.imme & ~(tlb_lo.v & (tlb_lo.vpn == req_vpn));
   // Fault only on a hit, keeps the flags exclusive
   assign fault_nxt = req_r.imme & ~miss_nxt & perm_denied;

   // Flags follow the command icache has taken
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tlb_miss   <= 1'b0;
         page_fault <= 1'b0;
      end else if (icache_fire) begin
         tlb_miss   <= miss_nxt;
         page_fault <= fault_nxt;
      end
   end

endmodule

`default_nettype wire

// File: include/imm_params.svh
// Width, paging and reset-vector macros for the instruction MMU; include wherever they are used
`ifndef IMM_PARAMS_SVH
`define IMM_PARAMS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Fetch address width
`define IMM_AW 32
// MSR and TLB word width
`define IMM_DW 32
// Instruction width
`define IMM_IW 32

//////////////////////////////////////////////////
// Paging and TLB geometry
//////////////////////////////////////////////////

// Page offset bits, 8 KB pages
`define IMM_PAGE_SHIFT 13
// Direct-mapped TLB, 128 sets
`define IMM_TLB_SETS_LOG2 7

// First fetch address after reset
`define IMM_RESET_VECTOR 32'h0000_0100

`endif

// File: verif/tb_clk_gen.sv
// Testbench clock and reset source; instantiated once by the testbench top
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset held for 10 cycles, released on a falling edge
   initial begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: verif/tb_imm_checker.sv
// Monitor for the instruction MMU; shadows the TLB, predicts every response and counts errors
`timescale 1ns/10ps
`default_nettype none

`include "imm_params.svh"

module tb_imm_checker
   import imm_pkg::*;
(
   input  wire     clk,
   input  wire     rst_n,
   input  wire     cmd_valid,
   input  wire     cmd_ready,
   input  addr_t   cmd_addr,
   input  wire     psr_imme,
   input  wire     psr_rm,
   input  wire     icache_cmd_valid,
   input  wire     icache_cmd_ready,
   input  addr_t   icache_cmd_addr,
   input  wire     flush_req,
   input  wire     flush_ack,
   input  wire     ibus_valid,
   input  wire     ibus_ready,
   input  insn_t   ibus_dout,
   input  wire     icache_valid,
   input  insn_t   icache_dout,
   input  wire     icache_ready,
   input  tlb_wr_t tlbl_wr,
   input  tlb_wr_t tlbh_wr,
   input  word_t   tlbl_rd,
   input  word_t   tlbh_rd,
   input  wire     tlb_miss,
   input  wire     page_fault,
   input  addr_t   out_id,
   input  addr_t   out_id_nxt,
   output int      errors,
   output int      checks,
   output int      pending
);

   localparam int SETS = 1 << `IMM_TLB_SETS_LOG2;

   word_t       shadow_lo [SETS];
   word_t       shadow_hi [SETS];
   // Expected {address, miss, fault} per accepted command
   logic [33:0] exp_q [$];
   logic        exp_miss;
   logic        exp_fault;
   addr_t       exp_id;
   addr_t       exp_nxt;
   word_t       exp_lrd;
   word_t       exp_hrd;
   logic        exp_rdy;
   logic        held;
   logic        up;
   logic        tlb_read;
   tlb_idx_t    idx;

   // Reference translation straight from the TLB word layout
   function automatic logic [33:0] ref_xlate(input addr_t a, input logic imme,
                                             input logic rm, input word_t lo, input word_t hi);
      logic hit;
      logic allowed;
      if (!imme) begin
         return {a, 2'b00};
      end
      hit     = lo[0] && (lo[31:13] == a[31:13]);
      // Bit 4 is rx, bit 3 is ux
      allowed = rm ? hi[4] : hi[3];
      return {hi[31:13], a[12:0], !hit, hit && !allowed};
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[ERROR] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("Check failed at %0t: %s", $time, what);
   endtask

   assign tlb_read = cmd_valid & cmd_ready;

   initial begin
      errors  = 0;
      checks  = 0;
      pending = 0;
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         exp_q.delete();
         exp_miss  = 1'b0;
         exp_fault = 1'b0;
         exp_id    = `IMM_RESET_VECTOR;
         exp_nxt   = `IMM_RESET_VECTOR - 32'd4;
         exp_lrd   = 'x;
         exp_hrd   = 'x;
         up        = 1'b0;
         pending   = 0;
      end else begin
         held    = exp_q.size() != 0;
         exp_rdy = up & (~held | icache_cmd_ready | flush_req);

         //////////////////////////////////////////////////
         // Registered outputs against the model
         //////////////////////////////////////////////////
         check_val("out_id", exp_id, out_id);
         check_val("out_id_nxt", exp_nxt, out_id_nxt);
         check_val("tlb_miss", exp_miss, tlb_miss);
         check_val("page_fault", exp_fault, page_fault);
         if (tlb_miss && page_fault) begin
            report_failure("tlb_miss and page_fault are both high");
         end
         if (!$isunknown(exp_lrd)) begin
            check_val("tlbl_rd", exp_lrd, tlbl_rd);
         end
         if (!$isunknown(exp_hrd)) begin
            check_val("tlbh_rd", exp_hrd, tlbh_rd);
         end

         //////////////////////////////////////////////////
         // Handshakes and data path
         //////////////////////////////////////////////////
         check_val("cmd_ready", exp_rdy, cmd_ready);
         // Flush pulses last one cycle and always strobe
         check_val("icache_cmd_valid", held & ~flush_req, icache_cmd_valid);
         check_val("flush_ack", cmd_valid & exp_rdy & ~flush_req, flush_ack);
         check_val("ibus_valid", icache_valid, ibus_valid);
         check_val("ibus_dout", icache_dout, ibus_dout);
         check_val("icache_ready", ibus_ready, icache_ready);

         //////////////////////////////////////////////////
         // Command stage
         //////////////////////////////////////////////////
         if (icache_cmd_valid && icache_cmd_ready) begin
            if (exp_q.size() == 0) begin
               report_failure("icache command issued with nothing accepted");
            end else begin
               check_val("icache_cmd_addr", exp_q[0][33:2], icache_cmd_addr);
               exp_miss  = exp_q[0][1];
               exp_fault = exp_q[0][0];
               void'(exp_q.pop_front());
            end
         end else if (flush_req && exp_q.size() > 0) begin
            // Held command dropped by the flush
            void'(exp_q.pop_front());
         end

         // Write-first read-back of the software ports
         exp_lrd = tlbl_wr.we ? tlbl_wr.data : shadow_lo[tlbl_wr.idx];
         exp_hrd = tlbh_wr.we ? tlbh_wr.data : shadow_hi[tlbh_wr.idx];
         if (tlbl_wr.we) begin
            shadow_lo[tlbl_wr.idx] = tlbl_wr.data;
         end
         if (tlbh_wr.we) begin
            shadow_hi[tlbh_wr.idx] = tlbh_wr.data;
         end

         // Lookup after the shadow update sees same-cycle writes
         if (tlb_read) begin
            idx = cmd_addr[19:13];
            exp_q.push_back(ref_xlate(cmd_addr, psr_imme, psr_rm,
                                      shadow_lo[idx], shadow_hi[idx]));
            if (exp_q.size() > 1) begin
               report_failure("second command accepted while one is held");
            end
         end

         // Address tracking
         if ((ibus_valid && ibus_ready) || flush_req) begin
            exp_id = flush_req ? cmd_addr : exp_nxt;
         end
         if (tlb_read) begin
            exp_nxt = cmd_addr;
         end

         up      = 1'b1;
         pending = exp_q.size();
      end
   end

endmodule

`default_nettype wire

// File: verif/tb_imm_top.sv
// Testbench top for the instruction MMU; drives fetches, models the icache, limits run time
`timescale 1ns/10ps
`default_nettype none

`include "imm_params.svh"

module tb_imm_top
   import imm_pkg::*;
;

   localparam logic [31:0] SEED = 32'h655b_231c;
   localparam int SETS        = 1 << `IMM_TLB_SETS_LOG2;
   localparam int N_PLAIN     = 40;
   localparam int N_MAP       = 60;
   localparam int N_BYP       = 8;
   localparam int N_FLUSH     = 10;
   // Each flush iteration issues two fetches
   localparam int N_FETCH     = N_PLAIN + N_MAP + N_BYP + 2 * N_FLUSH;
   // 20 cycles per issued fetch plus slack
   localparam int CYCLE_LIMIT = 20 * N_FETCH + 200;

   logic    clk;
   logic    rst_n;
   logic    cmd_valid;
   addr_t   cmd_addr;
   logic    cmd_ready;
   logic    ibus_valid;
   insn_t   ibus_dout;
   logic    ibus_ready;
   logic    icache_cmd_valid;
   addr_t   icache_cmd_addr;
   logic    icache_cmd_ready;
   logic    icache_valid;
   insn_t   icache_dout;
   logic    icache_ready;
   logic    flush_req;
   logic    flush_ack;
   logic    psr_imme;
   logic    psr_rm;
   tlb_wr_t tlbl_wr;
   tlb_wr_t tlbh_wr;
   word_t   tlbl_rd;
   word_t   tlbh_rd;
   logic    tlb_miss;
   logic    page_fault;
   addr_t   out_id;
   addr_t   out_id_nxt;
   int      errors;
   int      checks;
   int      pending;
   int      cycles;
   logic [31:0] drv_seed;
   logic [31:0] bp_seed;
   word_t   lo_img [SETS];
   addr_t   icache_q [$];

   tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

   imm_top dut (.*);

   tb_imm_checker u_chk (.*);

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] next_rand();
      drv_seed = lcg_next(drv_seed);
      return drv_seed;
   endfunction

   // Instruction word as a function of the fetch address
   function automatic insn_t insn_of(input addr_t a);
      return ~a ^ {a[15:0], a[31:16]};
   endfunction

   //////////////////////////////////////////////////
   // Icache model and back-pressure
   //////////////////////////////////////////////////

   initial begin
      bp_seed          = SEED ^ 32'h0000_0001;
      icache_cmd_ready = 1'b0;
      icache_valid     = 1'b0;
      icache_dout      = '0;
      ibus_ready       = 1'b0;
      forever begin
         @(negedge clk);
         // Data handshake of the last rising edge
         if (icache_valid && ibus_ready) begin
            void'(icache_q.pop_front());
         end
         bp_seed          = lcg_next(bp_seed);
         icache_cmd_ready = rst_n && (bp_seed[20:19] != 2'b00);
         ibus_ready       = bp_seed[25:24] != 2'b00;
         icache_valid     = (icache_q.size() > 0) && bp_seed[28];
         icache_dout      = (icache_q.size() > 0) ? insn_of(icache_q[0]) : '0;
      end
   end

   always @(posedge clk) begin
      if (icache_cmd_valid && icache_cmd_ready) begin
         icache_q.push_back(icache_cmd_addr);
      end
   end

   // Run limit
   initial cycles = 0;
   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, fetch traffic did not complete", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Fetch driver
   //////////////////////////////////////////////////

   // One fetch with an optional flush or TLB write in its first cycle
   task automatic fetch(input addr_t a, input logic imme, input logic rm,
                        input logic flush, input logic wr,
                        input word_t wlo, input word_t whi);
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd_addr  = a;
      psr_imme  = imme;
      psr_rm    = rm;
      flush_req = flush;
      if (wr) begin
         tlbl_wr = '{idx: a[19:13], we: 1'b1, data: wlo};
         tlbh_wr = '{idx: a[19:13], we: 1'b1, data: whi};
         lo_img[a[19:13]] = wlo;
      end
      forever begin
         @(posedge clk);
         if (cmd_ready) break;
      end
      @(negedge clk);
      cmd_valid  = 1'b0;
      flush_req  = 1'b0;
      tlbl_wr.we = 1'b0;
      tlbh_wr.we = 1'b0;
   endtask

   // Random entries whose vpn low bits equal the set
   task automatic make_entry(input tlb_idx_t idx, output word_t lo, output word_t hi);
      logic [31:0] r;
      r  = next_rand();
      lo = {r[31:20], idx, 12'h000, r[2:0] != 3'b000};
      r  = next_rand();
      hi = {r[31:13], 4'h0, r[8], 3'h0, r[4], r[3], 2'h0, r[0]};
   endtask

   // Address that hits the stored vpn about half the time
   function automatic addr_t pick_addr();
      logic [31:0] r;
      r = next_rand();
      if (r[31]) begin
         return {lo_img[r[19:13]][31:13], r[12:0]};
      end
      return r;
   endfunction

   initial begin
      word_t lo;
      word_t hi;
      addr_t a;
      drv_seed  = SEED;
      cmd_valid = 1'b0;
      cmd_addr  = '0;
      flush_req = 1'b0;
      psr_imme  = 1'b0;
      psr_rm    = 1'b0;
      tlbl_wr   = '0;
      tlbh_wr   = '0;
      @(posedge rst_n);

      // Fill the whole TLB through the software ports
      for (int i = 0; i < SETS; i++) begin
         make_entry(tlb_idx_t'(i), lo, hi);
         @(negedge clk);
         tlbl_wr   = '{idx: tlb_idx_t'(i), we: 1'b1, data: lo};
         tlbh_wr   = '{idx: tlb_idx_t'(i), we: 1'b1, data: hi};
         lo_img[i] = lo;
      end
      @(negedge clk);
      tlbl_wr.we = 1'b0;
      tlbh_wr.we = 1'b0;

      // Translation off
      for (int i = 0; i < N_PLAIN; i++) begin
         a = next_rand();
         fetch(a, 1'b0, a[0], 1'b0, 1'b0, '0, '0);
      end
      // Translation on with hits, misses and faults
      for (int i = 0; i < N_MAP; i++) begin
         a = pick_addr();
         fetch(a, 1'b1, next_rand() > 32'h8000_0000, 1'b0, 1'b0, '0, '0);
      end
      // Entry rewritten in the lookup cycle
      for (int i = 0; i < N_BYP; i++) begin
         a = next_rand();
         make_entry(a[19:13], lo, hi);
         if (i[0]) begin
            a[31:13] = lo[31:13];
         end
         fetch(a, 1'b1, a[5], 1'b0, 1'b1, lo, hi);
      end
      // Flushes with a new command presented
      for (int i = 0; i < N_FLUSH; i++) begin
         a = pick_addr();
         fetch(next_rand(), 1'b1, 1'b1, 1'b0, 1'b0, '0, '0);
         fetch(a, a[3], a[4], 1'b1, 1'b0, '0, '0);
      end

      // Drain outstanding commands and data
      while (pending != 0 || icache_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (5) @(posedge clk);
      $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
